// ==== ec_pkg.sv ====
package ec_pkg;

    // lane count and index width
    localparam int num_lanes = 4;
    localparam int lane_w    = 2;

    // coder state widths
    localparam int range_w = 16;
    localparam int low_w   = 24;
    localparam int shift_w = 5;

    // command field widths, probabilities are Q15 inverse CDF
    localparam int prob_w  = 16;
    localparam int sym_w   = 4;
    localparam int nsyms_w = 5;
    localparam int qprob_w = 10;
    localparam int off_w   = 7;
    localparam int seq_w   = 8;

    // reset state of every lane
    localparam logic [range_w-1:0] range_init = 16'd32768;
    localparam logic [low_w-1:0]   low_init   = 24'd0;
    localparam logic [shift_w-1:0] shift_init = 5'd0;

    // inverse CDF value that marks the first symbol
    localparam logic [prob_w-1:0] cdf_top = 16'd32768;

    // one 41 bit command word, cdf view or boolean view
    typedef union packed {
        struct packed {
            logic [prob_w-1:0]  fl;
            logic [prob_w-1:0]  fh;
            logic [sym_w-1:0]   symbol;
            logic [nsyms_w-1:0] nsyms;
        } cdf;
        struct packed {
            logic [prob_w-1:0] f;
            logic              bit_val;
            logic [23:0]       pad;
        } bool;
    } ec_cmd_u;

endpackage

// ==== symbol_dispatch.sv ====
module symbol_dispatch import ec_pkg::*; (
    input  logic                 general_clk,
    input  logic                 reset,
    input  logic                 cmd_valid,
    input  logic [lane_w-1:0]    cmd_lane,
    input  logic                 cmd_is_bool,
    input  ec_cmd_u              cmd_word,
    output logic [num_lanes-1:0] lane_strobe,
    output logic [prob_w-1:0]    fl,
    output logic [prob_w-1:0]    fh,
    output logic [sym_w-1:0]     symbol,
    output logic [nsyms_w-1:0]   nsyms
);

    logic [num_lanes-1:0] strobe_d;
    logic [prob_w-1:0]    fl_d;
    logic [prob_w-1:0]    fh_d;
    logic [sym_w-1:0]     symbol_d;
    logic [nsyms_w-1:0]   nsyms_d;

    // ------------------------------------------------------------------
    // command decode
    // ------------------------------------------------------------------
    always_comb begin
        if (cmd_is_bool) begin
            // boolean maps onto a two symbol cdf
            if (cmd_word.bool.bit_val) begin
                fl_d     = cmd_word.bool.f;
                fh_d     = '0;
                symbol_d = sym_w'(1);
            end else begin
                fl_d     = cdf_top;
                fh_d     = cmd_word.bool.f;
                symbol_d = '0;
            end
            nsyms_d = nsyms_w'(2);
        end else begin
            fl_d     = cmd_word.cdf.fl;
            fh_d     = cmd_word.cdf.fh;
            symbol_d = cmd_word.cdf.symbol;
            nsyms_d  = cmd_word.cdf.nsyms;
        end
    end

    // one-hot lane select
    always_comb begin
        for (int k = 0; k < num_lanes; k++) begin
            strobe_d[k] = cmd_valid && (cmd_lane == lane_w'(k));
        end
    end

    always_ff @(posedge general_clk) begin
        if (reset) begin
            lane_strobe <= '0;
        end else begin
            lane_strobe <= strobe_d;
        end
    end

    // shared bus to all lanes
    always_ff @(posedge general_clk) begin
        if (cmd_valid) begin
            fl     <= fl_d;
            fh     <= fh_d;
            symbol <= symbol_d;
            nsyms  <= nsyms_d;
        end
    end

endmodule

// ==== interval_scale.sv ====
module interval_scale import ec_pkg::*; (
    input  logic [prob_w-1:0]  fl,
    input  logic [prob_w-1:0]  fh,
    input  logic [sym_w-1:0]   symbol,
    input  logic [nsyms_w-1:0] nsyms,
    output logic [qprob_w-1:0] q_fl,
    output logic [qprob_w-1:0] q_fh,
    output logic [off_w-1:0]   u_off,
    output logic [off_w-1:0]   v_off,
    output logic               fl_top
);

    // symbols above the coded one, N - symbol
    logic [nsyms_w-1:0] rem;
    logic [nsyms_w-1:0] rem_plus;

    // ------------------------------------------------------------------
    // bound quantization
    // ------------------------------------------------------------------
    // drop the 6 low bits of each Q15 bound
    assign q_fl = qprob_w'(fl >> 6);
    assign q_fh = qprob_w'(fh >> 6);

    // first symbol carries fl at the top of the cdf
    assign fl_top = (fl >= cdf_top);

    // ------------------------------------------------------------------
    // minimum probability offsets
    // ------------------------------------------------------------------
    always_comb begin
        rem      = nsyms - nsyms_w'(1) - nsyms_w'(symbol);
        rem_plus = rem + nsyms_w'(1);
    end

    // 4 per remaining symbol
    assign u_off = off_w'({rem_plus, 2'b00});
    assign v_off = off_w'({rem, 2'b00});

endmodule

// ==== interval_update.sv ====
module interval_update import ec_pkg::*; (
    input  logic [qprob_w-1:0] q_fl,
    input  logic [qprob_w-1:0] q_fh,
    input  logic [off_w-1:0]   u_off,
    input  logic [off_w-1:0]   v_off,
    input  logic               fl_top,
    input  logic [range_w-1:0] range_in,
    input  logic [low_w-1:0]   low_in,
    input  logic [shift_w-1:0] shift_in,
    output logic [range_w-1:0] range_out,
    output logic [low_w-1:0]   low_out,
    output logic [shift_w-1:0] shift_out
);

    // range top byte times quantized bound
    logic [range_w-8+qprob_w-1:0] prod_fl;
    logic [range_w-8+qprob_w-1:0] prod_fh;

    // one spare bit above the range width
    logic [range_w:0] wide_r;
    logic [range_w:0] u;
    logic [range_w:0] v;

    logic [range_w-1:0] range_new;
    logic [low_w-1:0]   low_sum;
    logic [shift_w-1:0] msb_len;
    logic [shift_w-1:0] d;

    // ------------------------------------------------------------------
    // scaled interval bounds
    // ------------------------------------------------------------------
    always_comb begin
        prod_fl = range_in[range_w-1:8] * q_fl;
        prod_fh = range_in[range_w-1:8] * q_fh;
        wide_r  = {1'b0, range_in};
        u       = (range_w+1)'(prod_fl >> 1) + (range_w+1)'(u_off);
        v       = (range_w+1)'(prod_fh >> 1) + (range_w+1)'(v_off);
    end

    // interval select
    always_comb begin
        if (!fl_top) begin
            low_sum   = low_in + low_w'(wide_r - u);
            range_new = range_w'(u - v);
        end else begin
            // first symbol keeps low, trims the top of the range
            low_sum   = low_in;
            range_new = range_w'(wide_r - v);
        end
    end

    // ------------------------------------------------------------------
    // renormalization
    // ------------------------------------------------------------------
    // bit length of the new range
    always_comb begin
        msb_len = '0;
        for (int i = 0; i < range_w; i++) begin
            if (range_new[i]) begin
                msb_len = shift_w'(i + 1);
            end
        end
    end

    assign d = shift_w'(range_w) - msb_len;

    // low wraps at 24 bits, shift total at 5 bits
    assign range_out = range_new << d;
    assign low_out   = low_sum << d;
    assign shift_out = shift_in + d;

endmodule

// ==== ec_lane.sv ====
module ec_lane import ec_pkg::*; (
    input  logic               general_clk,
    input  logic               reset,
    input  logic               strobe,
    input  logic [prob_w-1:0]  fl,
    input  logic [prob_w-1:0]  fh,
    input  logic [sym_w-1:0]   symbol,
    input  logic [nsyms_w-1:0] nsyms,
    output logic               done,
    output logic [range_w-1:0] range,
    output logic [low_w-1:0]   low,
    output logic [shift_w-1:0] shift
);

    // stage 1 outputs
    logic [qprob_w-1:0] q_fl;
    logic [qprob_w-1:0] q_fh;
    logic [off_w-1:0]   u_off;
    logic [off_w-1:0]   v_off;
    logic               fl_top;

    // stage register
    logic               s_valid;
    logic [qprob_w-1:0] s_q_fl;
    logic [qprob_w-1:0] s_q_fh;
    logic [off_w-1:0]   s_u_off;
    logic [off_w-1:0]   s_v_off;
    logic               s_fl_top;

    // next state
    logic [range_w-1:0] range_nxt;
    logic [low_w-1:0]   low_nxt;
    logic [shift_w-1:0] shift_nxt;

    interval_scale scale (
        .fl     (fl),
        .fh     (fh),
        .symbol (symbol),
        .nsyms  (nsyms),
        .q_fl   (q_fl),
        .q_fh   (q_fh),
        .u_off  (u_off),
        .v_off  (v_off),
        .fl_top (fl_top)
    );

    // ------------------------------------------------------------------
    // stage register
    // ------------------------------------------------------------------
    always_ff @(posedge general_clk) begin
        if (reset) begin
            s_valid <= 1'b0;
        end else begin
            s_valid <= strobe;
        end
    end

    always_ff @(posedge general_clk) begin
        if (strobe) begin
            s_q_fl   <= q_fl;
            s_q_fh   <= q_fh;
            s_u_off  <= u_off;
            s_v_off  <= v_off;
            s_fl_top <= fl_top;
        end
    end

    interval_update update (
        .q_fl      (s_q_fl),
        .q_fh      (s_q_fh),
        .u_off     (s_u_off),
        .v_off     (s_v_off),
        .fl_top    (s_fl_top),
        .range_in  (range),
        .low_in    (low),
        .shift_in  (shift),
        .range_out (range_nxt),
        .low_out   (low_nxt),
        .shift_out (shift_nxt)
    );

    // ------------------------------------------------------------------
    // coder state, done tracks the write
    // ------------------------------------------------------------------
    always_ff @(posedge general_clk) begin
        if (reset) begin
            range <= range_init;
            low   <= low_init;
            shift <= shift_init;
            done  <= 1'b0;
        end else begin
            done <= s_valid;
            if (s_valid) begin
                range <= range_nxt;
                low   <= low_nxt;
                shift <= shift_nxt;
            end
        end
    end

endmodule

// ==== state_collector.sv ====
module state_collector import ec_pkg::*; (
    input  logic                 general_clk,
    input  logic                 reset,
    input  logic [num_lanes-1:0] lane_done,
    input  logic [range_w-1:0]   lane_range [num_lanes],
    input  logic [low_w-1:0]     lane_low   [num_lanes],
    input  logic [shift_w-1:0]   lane_shift [num_lanes],
    output logic                 result_valid,
    output logic [lane_w-1:0]    result_lane,
    output logic [seq_w-1:0]     result_seq,
    output logic [range_w-1:0]   result_range,
    output logic [low_w-1:0]     result_low,
    output logic [shift_w-1:0]   result_shift
);

    logic [lane_w-1:0] sel;
    logic              any_done;

    // per-lane result counters
    logic [seq_w-1:0] seq [num_lanes];

    // at most one lane completes per cycle
    always_comb begin
        sel      = '0;
        any_done = 1'b0;
        for (int k = 0; k < num_lanes; k++) begin
            if (lane_done[k]) begin
                sel      = lane_w'(k);
                any_done = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // sequence tags
    // ------------------------------------------------------------------
    always_ff @(posedge general_clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            for (int k = 0; k < num_lanes; k++) begin
                seq[k] <= '0;
            end
        end else begin
            result_valid <= any_done;
            if (any_done) begin
                seq[sel] <= seq[sel] + seq_w'(1);
            end
        end
    end

    // result payload
    always_ff @(posedge general_clk) begin
        if (any_done) begin
            result_lane  <= sel;
            result_seq   <= seq[sel];
            result_range <= lane_range[sel];
            result_low   <= lane_low[sel];
            result_shift <= lane_shift[sel];
        end
    end

endmodule

// ==== ec_multi_lane_top.sv ====
module ec_multi_lane_top import ec_pkg::*; (
    input  logic               general_clk,
    input  logic               reset,
    input  logic               cmd_valid,
    input  logic [lane_w-1:0]  cmd_lane,
    input  logic               cmd_is_bool,
    input  ec_cmd_u            cmd_word,
    output logic               result_valid,
    output logic [lane_w-1:0]  result_lane,
    output logic [seq_w-1:0]   result_seq,
    output logic [range_w-1:0] result_range,
    output logic [low_w-1:0]   result_low,
    output logic [shift_w-1:0] result_shift
);

    // shared command bus
    logic [num_lanes-1:0] lane_strobe;
    logic [prob_w-1:0]    fl;
    logic [prob_w-1:0]    fh;
    logic [sym_w-1:0]     symbol;
    logic [nsyms_w-1:0]   nsyms;

    // lane state back to the collector
    logic [num_lanes-1:0] lane_done;
    logic [range_w-1:0]   lane_range [num_lanes];
    logic [low_w-1:0]     lane_low   [num_lanes];
    logic [shift_w-1:0]   lane_shift [num_lanes];

    symbol_dispatch dispatch (
        .general_clk (general_clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_lane    (cmd_lane),
        .cmd_is_bool (cmd_is_bool),
        .cmd_word    (cmd_word),
        .lane_strobe (lane_strobe),
        .fl          (fl),
        .fh          (fh),
        .symbol      (symbol),
        .nsyms       (nsyms)
    );

    for (genvar k = 0; k < num_lanes; k++) begin : lane_gen
        ec_lane lane (
            .general_clk (general_clk),
            .reset       (reset),
            .strobe      (lane_strobe[k]),
            .fl          (fl),
            .fh          (fh),
            .symbol      (symbol),
            .nsyms       (nsyms),
            .done        (lane_done[k]),
            .range       (lane_range[k]),
            .low         (lane_low[k]),
            .shift       (lane_shift[k])
        );
    end

    state_collector collector (
        .general_clk  (general_clk),
        .reset        (reset),
        .lane_done    (lane_done),
        .lane_range   (lane_range),
        .lane_low     (lane_low),
        .lane_shift   (lane_shift),
        .result_valid (result_valid),
        .result_lane  (result_lane),
        .result_seq   (result_seq),
        .result_range (result_range),
        .result_low   (result_low),
        .result_shift (result_shift)
    );

endmodule

// ==== ec_assertions.sv ====
module ec_assertions import ec_pkg::*; (
    input logic                 general_clk,
    input logic                 reset,
    input logic [num_lanes-1:0] lane_done,
    input logic                 result_valid,
    input logic [range_w-1:0]   result_range
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // fixed latency lets only one lane finish per cycle
    done_onehot: assert property (@(posedge general_clk) disable iff (reset)
        $onehot0(lane_done))
    else begin
        fail_count++;
        $error("more than one lane done in the same cycle");
    end

    // renormalized range always has its top bit set
    range_normalized: assert property (@(posedge general_clk) disable iff (reset)
        result_valid |-> result_range[range_w-1])
    else begin
        fail_count++;
        $error("result range is not normalized");
    end

    valid_after_reset: assert property (@(posedge general_clk) reset |=> !result_valid)
    else begin
        fail_count++;
        $error("result valid high right after reset");
    end

endmodule

// ==== tb_ec.sv ====
module tb_ec import ec_pkg::*; ();

    // test lengths in commands
    localparam int reset_cycles = 5;
    localparam int idle_cycles  = 10;
    localparam int n_cdf        = 40;
    localparam int n_bool       = 24;
    localparam int n_burst      = 12;
    localparam int n_mixed      = 64;
    localparam int n_long       = 200;
    // cdf test leaves one idle cycle after each command
    localparam int cycle_limit  = reset_cycles + idle_cycles + 2 * n_cdf + n_bool + n_burst
                                + n_mixed + n_long + 20;

    typedef struct packed {
        logic [lane_w-1:0]  lane;
        logic [seq_w-1:0]   seq;
        logic [range_w-1:0] range;
        logic [low_w-1:0]   low;
        logic [shift_w-1:0] shift;
        int                 due;
    } exp_t;

    logic               general_clk;
    logic               reset;
    logic               cmd_valid;
    logic [lane_w-1:0]  cmd_lane;
    logic               cmd_is_bool;
    ec_cmd_u            cmd_word;
    logic               result_valid;
    logic [lane_w-1:0]  result_lane;
    logic [seq_w-1:0]   result_seq;
    logic [range_w-1:0] result_range;
    logic [low_w-1:0]   result_low;
    logic [shift_w-1:0] result_shift;

    // reference model state per lane
    int   model_range [num_lanes];
    int   model_low   [num_lanes];
    int   model_shift [num_lanes];
    int   model_seq   [num_lanes];
    exp_t expected_q [$];

    int cycle = 0;
    int value_errors = 0;
    int order_errors = 0;

    ec_multi_lane_top dut (.*);

    bind state_collector ec_assertions collector_checks (
        .general_clk  (general_clk),
        .reset        (reset),
        .lane_done    (lane_done),
        .result_valid (result_valid),
        .result_range (result_range)
    );

    initial begin
        general_clk = 1'b0;
        forever #5 general_clk = ~general_clk;
    end

    always @(posedge general_clk) cycle <= cycle + 1;

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic void ec_ref_encode(input int lane, input int fl, input int fh,
                                          input int sym, input int nsyms, input int due);
        int   r;
        int   n;
        int   su;
        int   sv;
        int   u;
        int   v;
        int   len;
        int   d;
        exp_t e;
        r  = model_range[lane];
        n  = nsyms - 1;
        su = ((r >> 8) * (fl >> 6)) >> 1;
        sv = ((r >> 8) * (fh >> 6)) >> 1;
        if (fl < 32768) begin
            u = su + 4 * (n - sym + 1);
            v = sv + 4 * (n - sym);
            model_low[lane] = (model_low[lane] + r - u) & 'hffffff;
            r = u - v;
        end else begin
            r = r - (sv + 4 * (n - sym));
        end
        len = 0;
        for (int i = 0; i < 16; i++) begin
            if ((r >> i) != 0) len = i + 1;
        end
        d = 16 - len;
        // only the low 24 bits of low survive, so int overflow is harmless
        model_range[lane] = r << d;
        model_low[lane]   = (model_low[lane] << d) & 'hffffff;
        model_shift[lane] = (model_shift[lane] + d) % 32;
        e.lane  = lane_w'(lane);
        e.seq   = seq_w'(model_seq[lane]);
        e.range = range_w'(model_range[lane]);
        e.low   = low_w'(model_low[lane]);
        e.shift = shift_w'(model_shift[lane]);
        e.due   = due;
        model_seq[lane] = (model_seq[lane] + 1) % 256;
        expected_q.push_back(e);
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_lane(input logic [lane_w-1:0] expected, input logic [lane_w-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR result_lane expected %h actual %h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_seq(input logic [seq_w-1:0] expected, input logic [seq_w-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR result_seq expected %h actual %h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_range(input logic [range_w-1:0] expected,
                               input logic [range_w-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR result_range expected %h actual %h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_low(input logic [low_w-1:0] expected, input logic [low_w-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR result_low expected %h actual %h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_shift(input logic [shift_w-1:0] expected,
                               input logic [shift_w-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR result_shift expected %h actual %h", expected, actual);
            value_errors++;
        end
    endtask

    // results are checked on the falling edge, away from the register updates
    always @(negedge general_clk) begin
        exp_t e;
        if (!reset && result_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("result on lane %0d arrived with no command outstanding", result_lane);
                order_errors++;
            end else begin
                e = expected_q.pop_front();
                check_lane(e.lane, result_lane);
                check_seq(e.seq, result_seq);
                check_range(e.range, result_range);
                check_low(e.low, result_low);
                check_shift(e.shift, result_shift);
                if (cycle != e.due) begin
                    $display("result for lane %0d came at cycle %0d instead of cycle %0d",
                             e.lane, cycle, e.due);
                    order_errors++;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic drive(input int lane, input logic is_bool, input ec_cmd_u word);
        @(negedge general_clk);
        cmd_valid   = 1'b1;
        cmd_lane    = lane_w'(lane);
        cmd_is_bool = is_bool;
        cmd_word    = word;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge general_clk);
            cmd_valid = 1'b0;
        end
    endtask

    // random symbol with a monotone inverse cdf around it
    task automatic send_cdf(input int lane);
        int      nsyms;
        int      sym;
        int      fl;
        int      fh;
        ec_cmd_u w;
        nsyms = $urandom_range(16, 2);
        sym   = $urandom_range(nsyms - 1, 0);
        fl    = (sym == 0) ? 32768 : $urandom_range(32767, 1);
        fh    = (sym == nsyms - 1) ? 0 : $urandom_range(fl - 1, 0);
        w            = '0;
        w.cdf.fl     = prob_w'(fl);
        w.cdf.fh     = prob_w'(fh);
        w.cdf.symbol = sym_w'(sym);
        w.cdf.nsyms  = nsyms_w'(nsyms);
        drive(lane, 1'b0, w);
        ec_ref_encode(lane, fl, fh, sym, nsyms, cycle + 4);
    endtask

    task automatic send_bool(input int lane, input int bit_val);
        int      f;
        ec_cmd_u w;
        f              = $urandom_range(32767, 1);
        w.bool.f       = prob_w'(f);
        w.bool.bit_val = bit_val[0];
        w.bool.pad     = 24'($urandom);
        drive(lane, 1'b1, w);
        // a boolean is a two symbol cdf
        if (bit_val != 0) ec_ref_encode(lane, f, 0, 1, 2, cycle + 4);
        else ec_ref_encode(lane, 32768, f, 0, 2, cycle + 4);
    endtask

    initial begin
        void'($urandom(32'hd63cc6d1));
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd_lane    = '0;
        cmd_is_bool = 1'b0;
        cmd_word    = '0;
        for (int k = 0; k < num_lanes; k++) begin
            model_range[k] = 32768;
            model_low[k]   = 0;
            model_shift[k] = 0;
            model_seq[k]   = 0;
        end
        repeat (reset_cycles) @(posedge general_clk);
        @(negedge general_clk);
        reset = 1'b0;
        // quiet period, no result may appear
        idle(idle_cycles);
        for (int i = 0; i < n_cdf; i++) begin
            send_cdf($urandom_range(num_lanes - 1, 0));
            idle(1);
        end
        for (int i = 0; i < n_bool; i++) send_bool($urandom_range(num_lanes - 1, 0), i % 2);
        for (int i = 0; i < n_burst; i++) send_cdf(2);
        for (int i = 0; i < n_mixed; i++) begin
            if ($urandom_range(1, 0) == 1) send_bool($urandom_range(num_lanes - 1, 0),
                                                     $urandom_range(1, 0));
            else send_cdf($urandom_range(num_lanes - 1, 0));
        end
        // long single lane run wraps low and the shift total
        for (int i = 0; i < n_long; i++) send_cdf(1);
        idle(1);
        wait (expected_q.size() == 0);
        idle(8);
        $display("errors: %0d value, %0d protocol, %0d assertion", value_errors, order_errors,
                 dut.collector.collector_checks.fail_count);
        if (value_errors == 0 && order_errors == 0
            && dut.collector.collector_checks.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycle == cycle_limit);
        $display("run stopped at cycle %0d with %0d results still outstanding",
                 cycle, expected_q.size());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
ec_pkg.sv
symbol_dispatch.sv
interval_scale.sv
interval_update.sv
ec_lane.sv
state_collector.sv
ec_multi_lane_top.sv
ec_assertions.sv
tb_ec.sv
